// File: filelist.f
+incdir+testbench
design/tlk_pkg.sv
design/tlk_lane_ctrl.sv
design/tlk_tx_gen.sv
design/tlk_rx_check.sv
design/tlk_axil_regs.sv
design/tlk_link_top.sv
testbench/tb_tlk_link.sv

// File: Bender.yml
package:
  name: tlk_link

sources:
  - files:
      - design/tlk_pkg.sv
      - design/tlk_lane_ctrl.sv
      - design/tlk_tx_gen.sv
      - design/tlk_rx_check.sv
      - design/tlk_axil_regs.sv
      - design/tlk_link_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_tlk_link.sv

// File: testbench/tb_tlk_tasks.svh
`ifndef TB_TLK_TASKS_SVH
`define TB_TLK_TASKS_SVH

task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge clk_80);
    axil_req.awaddr <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata <= data;
    axil_req.wstrb <= 4'hF;
    axil_req.wvalid <= 1'b1;
    axil_req.bready <= 1'b1;
    do @(negedge clk_80); while (!axil_rsp.awready);
    @(posedge clk_80); // address and data beats move here
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid <= 1'b0;
    do @(negedge clk_80); while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;
    @(posedge clk_80);
    axil_req.bready <= 1'b0;
endtask

task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    @(posedge clk_80);
    axil_req.araddr <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready <= 1'b1;
    do @(negedge clk_80); while (!axil_rsp.arready);
    @(posedge clk_80);
    axil_req.arvalid <= 1'b0;
    do @(negedge clk_80); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clk_80);
    axil_req.rready <= 1'b0;
endtask

task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
        $display("FAILED %s: expected 0x%04h, actual 0x%04h", name, exp, act);
        errors++;
    end
endtask

task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
        $display("FAILED %s: expected resp %b, actual resp %b", name, exp, act);
        errors++;
    end
endtask

task automatic check_tx(input string name, input tlk_pkg::tlk_tx_t exp,
                        input tlk_pkg::tlk_tx_t act);
    if (act !== exp) begin
        $display("FAILED %s: expected txd=%04h k=%b%b, actual txd=%04h k=%b%b", name,
                 exp.txd, exp.tkmsb, exp.tklsb, act.txd, act.tkmsb, act.tklsb);
        errors++;
    end
endtask

task automatic check_pins(input string name, input tlk_pkg::tlk_pins_t exp,
                          input tlk_pkg::tlk_pins_t act);
    if (act !== exp) begin
        $display("FAILED %s: expected pins %b, actual pins %b", name, exp, act);
        errors++;
    end
endtask

task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
        $display("test %-16s ok", name);
    end else begin
        tests_failed++;
        $display("test %-16s FAIL, %0d errors", name, errors - err0);
    end
endtask

task automatic send_ctrl(input string name, input int lane, input tlk_pkg::tlk_mode_e mode,
                         input logic start, input logic stop);
    logic [1:0] resp;
    axil_write(reg_addr(lane, tlk_pkg::REG_CTRL), {25'd0, mode, 2'b00, stop, start}, resp);
    check_resp({name, " ctrl write"}, tlk_pkg::RESP_OKAY, resp);
endtask

task automatic read_expect(input string name, input logic [7:0] addr, input logic [15:0] exp);
    logic [31:0] data;
    logic [1:0] resp;
    axil_read(addr, data, resp);
    check_resp(name, tlk_pkg::RESP_OKAY, resp);
    check_word(name, exp, data[15:0]);
    check_word({name, " hi"}, 16'h0000, data[31:16]);
endtask

task automatic expect_commas(input string name, input int lane,
                             input tlk_pkg::tlk_pins_t exp_pins, input int n);
    repeat (n) begin
        @(negedge clk_80);
        check_tx(name, comma_tx(), lane_tx(lane));
        check_pins(name, exp_pins, lane_pins(lane));
    end
endtask

// sync commas from enable and then n_data pattern words
task automatic watch_pattern(input string name, input int lane, input bit prbs,
                             input bit loop_pin, input int n_data);
    tlk_pkg::tlk_tx_t tx;
    tlk_pkg::tlk_pins_t exp_pins;
    logic [15:0] word;
    int commas;
    commas = 0;
    exp_pins = idle_pins();
    exp_pins.enable = 1'b1;
    exp_pins.loopen = loop_pin;
    @(negedge clk_80); // enable one cycle after the start pulse
    check_pins({name, " enable"}, exp_pins, lane_pins(lane));
    tx = lane_tx(lane);
    while (tx.tkmsb && tx.tklsb && (tx.txd == tlk_pkg::COMMA_WORD) &&
           (commas <= tlk_pkg::SYNC_WORDS)) begin
        commas++;
        @(negedge clk_80);
        tx = lane_tx(lane);
    end
    check_word({name, " sync commas"}, 16'(tlk_pkg::SYNC_WORDS), 16'(commas));
    word = prbs ? tlk_pkg::PRBS_SEED : 16'h0000;
    for (int i = 0; i < n_data; i++) begin
        if (i > 0) begin
            @(negedge clk_80);
            word = prbs ? lfsr_advance16(word) : word + 16'd1;
        end
        check_tx(name, {word, 2'b00}, lane_tx(lane)); // data words carry no k flags
        check_pins(name, exp_pins, lane_pins(lane));
    end
endtask

task automatic test_reset_regs();
    logic [31:0] data;
    logic [1:0] resp;
    int err0;
    err0 = errors;
    @(negedge clk_80);
    check_tx("reset_regs tx_a", comma_tx(), tx_a);
    check_tx("reset_regs tx_b", comma_tx(), tx_b);
    check_pins("reset_regs pins_a", idle_pins(), pins_a);
    check_pins("reset_regs pins_b", idle_pins(), pins_b);
    send_ctrl("reset_regs", 0, tlk_pkg::MODE_PRBS, 1'b0, 1'b0); // mode only
    read_expect("reset_regs ctrl_a", reg_addr(0, tlk_pkg::REG_CTRL),
                {9'd0, tlk_pkg::MODE_PRBS, 4'd0});
    send_ctrl("reset_regs", 1, tlk_pkg::MODE_CHIP_PRBS, 1'b0, 1'b0);
    read_expect("reset_regs ctrl_b", reg_addr(1, tlk_pkg::REG_CTRL),
                {9'd0, tlk_pkg::MODE_CHIP_PRBS, 4'd0});
    axil_write(8'h24, 32'h0000_0001, resp);
    check_resp("reset_regs bad write", tlk_pkg::RESP_SLVERR, resp);
    axil_read(8'h24, data, resp);
    check_resp("reset_regs bad read", tlk_pkg::RESP_SLVERR, resp);
    check_word("reset_regs bad read lo", 16'h0000, data[15:0]);
    check_word("reset_regs bad read hi", 16'h0000, data[31:16]);
    finish_test("reset_regs", err0);
endtask

task automatic test_count_lane_a();
    int err0;
    int base;
    err0 = errors;
    base = data_cnt[0];
    send_ctrl("count_a", 0, tlk_pkg::MODE_COUNT, 1'b1, 1'b0);
    watch_pattern("count_a", 0, 1'b0, 1'b0, 100);
    send_ctrl("count_a", 0, tlk_pkg::MODE_COUNT, 1'b0, 1'b1);
    // first data word is only the reference
    read_expect("count_a words", reg_addr(0, tlk_pkg::REG_WORDS), 16'(data_cnt[0] - base - 1));
    read_expect("count_a errs", reg_addr(0, tlk_pkg::REG_ERRS), 16'h0000);
    finish_test("count_a", err0);
endtask

task automatic test_prbs_lane_b();
    logic [15:0] mask;
    int err0;
    int base;
    err0 = errors;
    base = data_cnt[1];
    mask = 16'($urandom) | 16'h0001;
    send_ctrl("prbs_b", 1, tlk_pkg::MODE_PRBS, 1'b1, 1'b0);
    watch_pattern("prbs_b", 1, 1'b1, 1'b0, 40);
    @(posedge clk_80);
    corrupt_b <= mask;
    @(posedge clk_80);
    corrupt_b <= '0; // exactly one word corrupted
    repeat (20) @(posedge clk_80);
    send_ctrl("prbs_b", 1, tlk_pkg::MODE_PRBS, 1'b0, 1'b1);
    read_expect("prbs_b words", reg_addr(1, tlk_pkg::REG_WORDS), 16'(data_cnt[1] - base - 1));
    read_expect("prbs_b errs", reg_addr(1, tlk_pkg::REG_ERRS), 16'd2);
    finish_test("prbs_b", err0);
endtask

task automatic test_stop_handshake();
    int err0;
    err0 = errors;
    // lane b is still stopped after the prbs run
    read_expect("stop_b stat", reg_addr(1, tlk_pkg::REG_STAT), 16'h0002);
    read_expect("stop_b errs held", reg_addr(1, tlk_pkg::REG_ERRS), 16'd2);
    expect_commas("stop_b idle", 1, idle_pins(), 4);
    send_ctrl("stop_b", 1, tlk_pkg::MODE_COUNT, 1'b1, 1'b0);
    read_expect("stop_b restart stat", reg_addr(1, tlk_pkg::REG_STAT), 16'h0001);
    read_expect("stop_b restart words", reg_addr(1, tlk_pkg::REG_WORDS), 16'h0000);
    read_expect("stop_b restart errs", reg_addr(1, tlk_pkg::REG_ERRS), 16'h0000);
    repeat (20) @(posedge clk_80);
    read_expect("stop_b run stat", reg_addr(1, tlk_pkg::REG_STAT), 16'h0005); // running and locked
    send_ctrl("stop_b", 1, tlk_pkg::MODE_COUNT, 1'b0, 1'b1);
    expect_commas("stop_b after stop", 1, idle_pins(), 4);
    read_expect("stop_b stat again", reg_addr(1, tlk_pkg::REG_STAT), 16'h0002);
    finish_test("stop_b", err0);
endtask

task automatic test_special_modes();
    tlk_pkg::tlk_pins_t chip_pins;
    int err0;
    int base;
    err0 = errors;
    base = data_cnt[0];
    chip_pins = idle_pins();
    chip_pins.enable = 1'b1;
    chip_pins.prbsen = 1'b1;
    send_ctrl("special", 1, tlk_pkg::MODE_CHIP_PRBS, 1'b1, 1'b0);
    send_ctrl("special", 0, tlk_pkg::MODE_LOOP, 1'b1, 1'b0);
    watch_pattern("special loop_a", 0, 1'b0, 1'b1, 60);
    expect_commas("special chip_prbs_b", 1, chip_pins, 4);
    send_ctrl("special", 0, tlk_pkg::MODE_LOOP, 1'b0, 1'b1);
    send_ctrl("special", 1, tlk_pkg::MODE_CHIP_PRBS, 1'b0, 1'b1);
    read_expect("special words_a", reg_addr(0, tlk_pkg::REG_WORDS), 16'(data_cnt[0] - base - 1));
    read_expect("special errs_a", reg_addr(0, tlk_pkg::REG_ERRS), 16'h0000);
    read_expect("special words_b", reg_addr(1, tlk_pkg::REG_WORDS), 16'h0000);
    read_expect("special errs_b", reg_addr(1, tlk_pkg::REG_ERRS), 16'h0000);
    finish_test("special", err0);
endtask

`endif

// File: testbench/tb_tlk_link.sv
module tb_tlk_link;

    timeunit 1ns;
    timeprecision 1ps;

    // expected test lengths in cycles
    localparam int LEN_RESET = 40;
    localparam int LEN_COUNT = 150;
    localparam int LEN_PRBS = 110;
    localparam int LEN_STOP = 80;
    localparam int LEN_SPECIAL = 120;
    localparam int WATCHDOG_CYCLES = 2 * (LEN_RESET + LEN_COUNT + LEN_PRBS + LEN_STOP +
                                          LEN_SPECIAL);

    logic clk_80;
    logic rst_80;
    tlk_pkg::axil_req_t axil_req;
    tlk_pkg::axil_rsp_t axil_rsp;
    tlk_pkg::tlk_tx_t tx_a;
    tlk_pkg::tlk_tx_t tx_b;
    tlk_pkg::tlk_rx_t rx_a;
    tlk_pkg::tlk_rx_t rx_b;
    tlk_pkg::tlk_pins_t pins_a;
    tlk_pkg::tlk_pins_t pins_b;
    logic [15:0] corrupt_a; // xor mask into lane a rxd
    logic [15:0] corrupt_b;
    int data_cnt [2];       // data words seen on each tx lane
    int cycles;
    int errors;
    int tests_run;
    int tests_failed;

    tlk_link_top i_dut (
        .i_clk_80 (clk_80),
        .i_rst_80 (rst_80),
        .i_axil   (axil_req),
        .o_axil   (axil_rsp),
        .o_tx_a   (tx_a),
        .o_tx_b   (tx_b),
        .i_rx_a   (rx_a),
        .i_rx_b   (rx_b),
        .o_pins_a (pins_a),
        .o_pins_b (pins_b)
    );

    initial begin
        clk_80 = 1'b0;
        forever #5 clk_80 = ~clk_80;
    end

    // loopback with one register stage per lane
    always @(posedge clk_80) begin
        rx_a <= {tx_a.txd ^ corrupt_a, tx_a.tkmsb, tx_a.tklsb};
        rx_b <= {tx_b.txd ^ corrupt_b, tx_b.tkmsb, tx_b.tklsb};
    end

    always @(negedge clk_80) begin
        if (!tx_a.tkmsb && !tx_a.tklsb) begin
            data_cnt[0]++;
        end
        if (!tx_b.tkmsb && !tx_b.tklsb) begin
            data_cnt[1]++;
        end
    end

    // reference LFSR as the bit recurrence b[n] = b[n-16]^b[n-14]^b[n-13]^b[n-11]
    function automatic logic [15:0] lfsr_advance16(input logic [15:0] cur);
        logic seq [0:31];
        logic [15:0] nxt;
        for (int i = 0; i < 16; i++) begin
            seq[i] = cur[15 - i]; // oldest bit first
        end
        for (int n = 16; n < 32; n++) begin
            seq[n] = seq[n - 16] ^ seq[n - 14] ^ seq[n - 13] ^ seq[n - 11];
        end
        for (int i = 0; i < 16; i++) begin
            nxt[15 - i] = seq[16 + i];
        end
        return nxt;
    endfunction

    function automatic tlk_pkg::tlk_tx_t comma_tx();
        tlk_pkg::tlk_tx_t t;
        t.txd = tlk_pkg::COMMA_WORD;
        t.tkmsb = 1'b1;
        t.tklsb = 1'b1;
        return t;
    endfunction

    function automatic tlk_pkg::tlk_pins_t idle_pins();
        tlk_pkg::tlk_pins_t p;
        p = '0;
        p.lckrefn = 1'b1;
        return p;
    endfunction

    function automatic tlk_pkg::tlk_tx_t lane_tx(input int lane);
        return (lane == 0) ? tx_a : tx_b;
    endfunction

    function automatic tlk_pkg::tlk_pins_t lane_pins(input int lane);
        return (lane == 0) ? pins_a : pins_b;
    endfunction

    function automatic logic [7:0] reg_addr(input int lane, input logic [3:0] off);
        return (lane == 0) ? {4'h0, off} : tlk_pkg::LANE_STRIDE + {4'h0, off};
    endfunction

    `include "tb_tlk_tasks.svh"

    initial begin
        cycles = 0;
        while (cycles < WATCHDOG_CYCLES) begin
            @(posedge clk_80);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(12713));
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        data_cnt[0] = 0;
        data_cnt[1] = 0;
        axil_req = '0;
        corrupt_a = '0;
        corrupt_b = '0;
        rx_a = '0;
        rx_b = '0;
        rst_80 = 1'b1;
        repeat (2) @(posedge clk_80);
        rst_80 <= 1'b0;
        test_reset_regs();
        test_count_lane_a();
        test_prbs_lane_b();
        test_stop_handshake();
        test_special_modes();
        $display("summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: design/tlk_link_top.sv
module tlk_link_top (
    input  logic               i_clk_80,
    input  logic               i_rst_80,
    input  tlk_pkg::axil_req_t i_axil,
    output tlk_pkg::axil_rsp_t o_axil,
    output tlk_pkg::tlk_tx_t   o_tx_a,
    output tlk_pkg::tlk_tx_t   o_tx_b,
    input  tlk_pkg::tlk_rx_t   i_rx_a,
    input  tlk_pkg::tlk_rx_t   i_rx_b,
    output tlk_pkg::tlk_pins_t o_pins_a,
    output tlk_pkg::tlk_pins_t o_pins_b
);

    tlk_pkg::lane_cmd_t cmd [tlk_pkg::NUM_LANES];
    tlk_pkg::lane_stat_t stat [tlk_pkg::NUM_LANES];
    tlk_pkg::tlk_tx_t tx [tlk_pkg::NUM_LANES];
    tlk_pkg::tlk_rx_t rx [tlk_pkg::NUM_LANES];
    tlk_pkg::tlk_pins_t pins [tlk_pkg::NUM_LANES];

    tlk_axil_regs regs_inst (
        .i_clk_80 (i_clk_80),
        .i_rst_80 (i_rst_80),
        .i_axil   (i_axil),
        .o_axil   (o_axil),
        .o_cmd_a  (cmd[0]),
        .o_cmd_b  (cmd[1]),
        .i_stat_a (stat[0]),
        .i_stat_b (stat[1])
    );

    // lane 0 is A, lane 1 is B
    assign rx[0] = i_rx_a;
    assign rx[1] = i_rx_b;
    assign o_tx_a = tx[0];
    assign o_tx_b = tx[1];
    assign o_pins_a = pins[0];
    assign o_pins_b = pins[1];

    for (genvar i = 0; i < tlk_pkg::NUM_LANES; i++) begin : g_lane
        tlk_pkg::lane_state_e state;
        tlk_pkg::tlk_mode_e mode;
        logic clear;
        logic running;
        logic stop_ack;
        logic locked;
        logic [15:0] words;
        logic [15:0] errors;

        tlk_lane_ctrl ctrl_inst (
            .i_clk_80   (i_clk_80),
            .i_rst_80   (i_rst_80),
            .i_cmd      (cmd[i]),
            .o_pins     (pins[i]),
            .o_state    (state),
            .o_mode     (mode),
            .o_clear    (clear),
            .o_running  (running),
            .o_stop_ack (stop_ack)
        );

        tlk_tx_gen tx_inst (
            .i_clk_80 (i_clk_80),
            .i_rst_80 (i_rst_80),
            .i_state  (state),
            .i_mode   (mode),
            .o_tx     (tx[i])
        );

        tlk_rx_check rx_inst (
            .i_clk_80 (i_clk_80),
            .i_rst_80 (i_rst_80),
            .i_clear  (clear),
            .i_mode   (mode),
            .i_rx     (rx[i]),
            .o_locked (locked),
            .o_words  (words),
            .o_errors (errors)
        );

        assign stat[i] = {running, stop_ack, locked, words, errors};
    end

endmodule

// File: design/tlk_axil_regs.sv
module tlk_axil_regs (
    input  logic                i_clk_80,
    input  logic                i_rst_80,
    input  tlk_pkg::axil_req_t  i_axil,
    output tlk_pkg::axil_rsp_t  o_axil,
    output tlk_pkg::lane_cmd_t  o_cmd_a,
    output tlk_pkg::lane_cmd_t  o_cmd_b,
    input  tlk_pkg::lane_stat_t i_stat_a,
    input  tlk_pkg::lane_stat_t i_stat_b
);

    tlk_pkg::lane_cmd_t cmd_q [tlk_pkg::NUM_LANES];
    tlk_pkg::lane_stat_t stat [tlk_pkg::NUM_LANES];
    tlk_pkg::lane_stat_t rd_stat;
    logic wr_ready_q;
    logic rd_ready_q;
    logic bvalid_q;
    logic rvalid_q;
    logic [1:0] bresp_q;
    logic [1:0] rresp_q;
    logic [31:0] rdata_q;
    logic [31:0] rd_data;
    logic wr_fire;
    logic rd_fire;
    logic wr_lane;
    logic rd_lane;
    logic [3:0] wr_off;
    logic [3:0] rd_off;
    logic wr_ok;
    logic rd_ok;

    // inside the two lane windows and word aligned
    function automatic logic addr_ok(input logic [7:0] addr);
        return (addr < 2 * tlk_pkg::LANE_STRIDE) && (addr[1:0] == 2'b00);
    endfunction

    function automatic logic addr_lane(input logic [7:0] addr);
        return addr >= tlk_pkg::LANE_STRIDE;
    endfunction

    assign stat[0] = i_stat_a;
    assign stat[1] = i_stat_b;

    assign wr_fire = wr_ready_q && i_axil.awvalid && i_axil.wvalid;
    assign rd_fire = rd_ready_q && i_axil.arvalid;
    assign wr_lane = addr_lane(i_axil.awaddr);
    assign rd_lane = addr_lane(i_axil.araddr);
    assign wr_off = i_axil.awaddr[3:0];
    assign rd_off = i_axil.araddr[3:0];
    assign wr_ok = addr_ok(i_axil.awaddr);
    assign rd_ok = addr_ok(i_axil.araddr);

    always_ff @(posedge i_clk_80) begin
        if (i_rst_80) begin
            wr_ready_q <= 1'b0;
            rd_ready_q <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            for (int i = 0; i < tlk_pkg::NUM_LANES; i++) begin
                cmd_q[i] <= '0;
            end
        end else begin
            // ready for one cycle, only while no response is pending
            wr_ready_q <= !wr_ready_q && !bvalid_q && i_axil.awvalid && i_axil.wvalid;
            rd_ready_q <= !rd_ready_q && !rvalid_q && i_axil.arvalid;
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (i_axil.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (i_axil.rready) begin
                rvalid_q <= 1'b0;
            end
            for (int i = 0; i < tlk_pkg::NUM_LANES; i++) begin
                cmd_q[i].start <= 1'b0;
                cmd_q[i].stop <= 1'b0;
            end
            if (wr_fire && wr_ok && (wr_off == tlk_pkg::REG_CTRL) && i_axil.wstrb[0]) begin
                cmd_q[wr_lane].start <= i_axil.wdata[0];
                cmd_q[wr_lane].stop <= i_axil.wdata[1];
                cmd_q[wr_lane].mode <= tlk_pkg::tlk_mode_e'(i_axil.wdata[6:4]);
            end
        end
    end

    always_comb begin
        rd_stat = stat[rd_lane];
        rd_data = '0;
        if (rd_ok) begin
            case (rd_off)
                tlk_pkg::REG_CTRL: rd_data[6:4] = cmd_q[rd_lane].mode;
                tlk_pkg::REG_STAT: rd_data[2:0] = {rd_stat.locked, rd_stat.stop_ack,
                                                   rd_stat.running};
                tlk_pkg::REG_WORDS: rd_data[15:0] = rd_stat.words;
                tlk_pkg::REG_ERRS: rd_data[15:0] = rd_stat.errors;
                default: rd_data = '0;
            endcase
        end
    end

    // response payload
    always_ff @(posedge i_clk_80) begin
        if (wr_fire) begin
            bresp_q <= wr_ok ? tlk_pkg::RESP_OKAY : tlk_pkg::RESP_SLVERR;
        end
        if (rd_fire) begin
            rdata_q <= rd_data;
            rresp_q <= rd_ok ? tlk_pkg::RESP_OKAY : tlk_pkg::RESP_SLVERR;
        end
    end

    always_comb begin
        o_axil.awready = wr_ready_q;
        o_axil.wready = wr_ready_q;
        o_axil.bresp = bresp_q;
        o_axil.bvalid = bvalid_q;
        o_axil.arready = rd_ready_q;
        o_axil.rdata = rdata_q;
        o_axil.rresp = rresp_q;
        o_axil.rvalid = rvalid_q;
    end

    assign o_cmd_a = cmd_q[0];
    assign o_cmd_b = cmd_q[1];

endmodule

// File: design/tlk_rx_check.sv
module tlk_rx_check (
    input  logic               i_clk_80,
    input  logic               i_rst_80,
    input  logic               i_clear,
    input  tlk_pkg::tlk_mode_e i_mode,
    input  tlk_pkg::tlk_rx_t   i_rx,
    output logic               o_locked,
    output logic [15:0]        o_words,
    output logic [15:0]        o_errors
);

    logic is_comma;
    logic counting;
    logic seen_comma_q;
    logic locked_q;
    logic mismatch;
    logic [15:0] prev_q;
    logic [15:0] expect_word;
    logic [15:0] words_q;
    logic [15:0] errors_q;

    assign is_comma = i_rx.rkmsb && i_rx.rklsb && (i_rx.rxd == tlk_pkg::COMMA_WORD);

    always_comb begin
        counting = 1'b0;
        case (i_mode)
            tlk_pkg::MODE_COUNT,
            tlk_pkg::MODE_LOOP,
            tlk_pkg::MODE_PRBS: counting = 1'b1;
            default: counting = 1'b0;
        endcase
    end

    // prediction from the last received data word
    assign expect_word = (i_mode == tlk_pkg::MODE_PRBS) ? tlk_pkg::prbs_next(prev_q) :
                                                          prev_q + 16'd1;
    assign mismatch = (i_rx.rxd != expect_word);

    always_ff @(posedge i_clk_80) begin
        if (!is_comma) begin
            prev_q <= i_rx.rxd; // follow what arrived, not what was expected
        end
    end

    always_ff @(posedge i_clk_80) begin
        if (i_rst_80 || i_clear) begin
            seen_comma_q <= 1'b0;
            locked_q <= 1'b0;
            words_q <= '0;
            errors_q <= '0;
        end else if (is_comma) begin
            seen_comma_q <= 1'b1;
            locked_q <= 1'b0; // comma ends a checked run
        end else if (counting) begin
            if (locked_q) begin
                if (words_q != 16'hFFFF) begin
                    words_q <= words_q + 16'd1;
                end
                if (mismatch && (errors_q != 16'hFFFF)) begin
                    errors_q <= errors_q + 16'd1;
                end
            end else if (seen_comma_q) begin
                // first data word after a comma is the reference
                locked_q <= 1'b1;
            end
        end
    end

    assign o_locked = locked_q;
    assign o_words = words_q;
    assign o_errors = errors_q;

endmodule

// File: design/tlk_tx_gen.sv
module tlk_tx_gen (
    input  logic                 i_clk_80,
    input  logic                 i_rst_80,
    input  tlk_pkg::lane_state_e i_state,
    input  tlk_pkg::tlk_mode_e   i_mode,
    output tlk_pkg::tlk_tx_t     o_tx
);

    logic [15:0] cnt_q;
    logic [15:0] prbs_q;
    logic in_run;

    assign in_run = (i_state == tlk_pkg::ST_RUN);

    // pattern state reloads during sync so the first data word is fixed
    always_ff @(posedge i_clk_80) begin
        if (i_rst_80) begin
            cnt_q <= '0;
            prbs_q <= tlk_pkg::PRBS_SEED;
        end else if (i_state == tlk_pkg::ST_SYNC) begin
            cnt_q <= '0;
            prbs_q <= tlk_pkg::PRBS_SEED;
        end else if (in_run) begin
            cnt_q <= cnt_q + 16'd1;
            prbs_q <= tlk_pkg::prbs_next(prbs_q);
        end
    end

    always_comb begin
        // default is the idle comma with both k flags
        o_tx.txd = tlk_pkg::COMMA_WORD;
        o_tx.tkmsb = 1'b1;
        o_tx.tklsb = 1'b1;
        if (in_run) begin
            case (i_mode)
                tlk_pkg::MODE_COUNT,
                tlk_pkg::MODE_LOOP: begin
                    o_tx.txd = cnt_q;
                    o_tx.tkmsb = 1'b0;
                    o_tx.tklsb = 1'b0;
                end
                tlk_pkg::MODE_PRBS: begin
                    o_tx.txd = prbs_q;
                    o_tx.tkmsb = 1'b0;
                    o_tx.tklsb = 1'b0;
                end
                default: ; // comma and chip prbs keep commas
            endcase
        end
    end

endmodule

// File: design/tlk_lane_ctrl.sv
module tlk_lane_ctrl (
    input  logic                 i_clk_80,
    input  logic                 i_rst_80,
    input  tlk_pkg::lane_cmd_t   i_cmd,
    output tlk_pkg::tlk_pins_t   o_pins,
    output tlk_pkg::lane_state_e o_state,
    output tlk_pkg::tlk_mode_e   o_mode,
    output logic                 o_clear,
    output logic                 o_running,
    output logic                 o_stop_ack
);

    tlk_pkg::lane_state_e state_q;
    tlk_pkg::tlk_mode_e mode_q;
    logic [tlk_pkg::SYNC_CNT_W-1:0] sync_cnt_q;
    logic clear_q;
    logic stop_ack_q;
    logic start_ok;
    logic stop_ok;
    logic running;

    // start only counts from idle, stop only while active
    assign start_ok = i_cmd.start && (state_q == tlk_pkg::ST_IDLE);
    assign stop_ok = i_cmd.stop && (state_q != tlk_pkg::ST_IDLE);
    assign running = (state_q != tlk_pkg::ST_IDLE);

    always_ff @(posedge i_clk_80) begin
        if (i_rst_80) begin
            state_q <= tlk_pkg::ST_IDLE;
            mode_q <= tlk_pkg::MODE_COMMA;
            sync_cnt_q <= '0;
            clear_q <= 1'b0;
            stop_ack_q <= 1'b0;
        end else begin
            clear_q <= start_ok; // lines up with the new mode
            if (start_ok) begin
                mode_q <= i_cmd.mode;
                stop_ack_q <= 1'b0;
                sync_cnt_q <= '0;
            end
            if (stop_ok) begin
                stop_ack_q <= 1'b1; // held until next start
            end
            case (state_q)
                tlk_pkg::ST_IDLE: begin
                    if (start_ok) begin
                        state_q <= tlk_pkg::ST_SYNC;
                    end
                end
                tlk_pkg::ST_SYNC: begin
                    if (stop_ok) begin
                        state_q <= tlk_pkg::ST_IDLE;
                    end else if (sync_cnt_q == tlk_pkg::SYNC_LAST) begin
                        state_q <= tlk_pkg::ST_RUN;
                    end else begin
                        sync_cnt_q <= sync_cnt_q + 1'b1;
                    end
                end
                tlk_pkg::ST_RUN: begin
                    if (stop_ok) begin
                        state_q <= tlk_pkg::ST_IDLE;
                    end
                end
                default: state_q <= tlk_pkg::ST_IDLE;
            endcase
        end
    end

    always_comb begin
        o_pins = '0;
        o_pins.enable = running;
        o_pins.lckrefn = 1'b1; // receiver tracks the incoming data
        o_pins.loopen = running && (mode_q == tlk_pkg::MODE_LOOP);
        o_pins.prbsen = running && (mode_q == tlk_pkg::MODE_CHIP_PRBS);
        o_pins.testen = 1'b0;
    end

    assign o_state = state_q;
    assign o_mode = mode_q;
    assign o_clear = clear_q;
    assign o_running = running;
    assign o_stop_ack = stop_ack_q;

endmodule

// File: design/tlk_pkg.sv
package tlk_pkg;

    localparam int NUM_LANES = 2;

    // K28.5 on both bytes
    localparam logic [15:0] COMMA_WORD = 16'hBCBC;
    localparam int SYNC_WORDS = 8;
    localparam int SYNC_CNT_W = $clog2(SYNC_WORDS);
    localparam logic [SYNC_CNT_W-1:0] SYNC_LAST = SYNC_CNT_W'(SYNC_WORDS - 1);
    localparam logic [15:0] PRBS_SEED = 16'hACE1;

    // register map, byte offsets
    localparam logic [7:0] LANE_STRIDE = 8'h10;
    localparam logic [3:0] REG_CTRL = 4'h0;
    localparam logic [3:0] REG_STAT = 4'h4;
    localparam logic [3:0] REG_WORDS = 4'h8;
    localparam logic [3:0] REG_ERRS = 4'hC;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [2:0] {
        MODE_COMMA = 3'd0,
        MODE_COUNT = 3'd1,
        MODE_PRBS = 3'd2,
        MODE_LOOP = 3'd3,     // count data, chip loopback pin set
        MODE_CHIP_PRBS = 3'd4 // chip internal prbs, commas on txd
    } tlk_mode_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_SYNC = 2'd1,
        ST_RUN = 2'd2
    } lane_state_e;

    typedef struct packed {
        logic [15:0] txd;
        logic tkmsb;
        logic tklsb;
    } tlk_tx_t;

    typedef struct packed {
        logic [15:0] rxd;
        logic rkmsb;
        logic rklsb;
    } tlk_rx_t;

    // phy control pins
    typedef struct packed {
        logic loopen;
        logic prbsen;
        logic enable;
        logic lckrefn;
        logic testen;
    } tlk_pins_t;

    typedef struct packed {
        logic start; // one-cycle pulse
        logic stop;  // one-cycle pulse
        tlk_mode_e mode;
    } lane_cmd_t;

    typedef struct packed {
        logic running;
        logic stop_ack;
        logic locked;
        logic [15:0] words;
        logic [15:0] errors;
    } lane_stat_t;

    typedef struct packed {
        logic [7:0] awaddr;
        logic awvalid;
        logic [31:0] wdata;
        logic [3:0] wstrb;
        logic wvalid;
        logic bready;
        logic [7:0] araddr;
        logic arvalid;
        logic rready;
    } axil_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic [1:0] bresp;
        logic bvalid;
        logic arready;
        logic [31:0] rdata;
        logic [1:0] rresp;
        logic rvalid;
    } axil_rsp_t;

    // x^16+x^14+x^13+x^11+1, 16 shifts per word
    function automatic logic [15:0] prbs_next(input logic [15:0] cur);
        logic [15:0] s;
        logic fb;
        s = cur;
        for (int i = 0; i < 16; i++) begin
            fb = s[15] ^ s[13] ^ s[12] ^ s[10];
            s = {s[14:0], fb};
        end
        return s;
    endfunction

endpackage
